// File: dv/board_ctrl_vectors.txt
# op addr data in hex; W write, R read and expect data, A write cut after 12 bits
# S drives a status input named by its read address (04 mac_link 05 channel_up 24 mdio_i)
R 00 2024
R 01 0517
R 02 0013
R 03 4500
R 30 0000
R 7f 0000
W 20 fff5
R 20 0005
W 21 0003
R 21 0001
W 22 0001
R 22 0001
W 23 ffff
R 23 0001
S 24 0001
R 24 0001
S 24 0000
R 24 0000
S 04 000a
R 04 000a
S 05 0001
R 05 0001
S 05 0000
R 05 0000
A 20 000f
R 20 0005
W 20 000f
R 20 000f
W 00 1234
R 00 2024

// File: board_ctrl_top.f
common/board_ctrl_pkg.sv
spi/spi_sampler.sv
spi/spi_deframer.sv
source/reg_bank.sv
source/board_ctrl_top.sv
dv/board_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the board control testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := board_ctrl_tb
FILELIST  := board_ctrl_top.f
BIN       := obj_dir/V$(TOP)
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/board_ctrl_tb.sv
/*
 * board control testbench
 * bit-bangs spi frames from the vector file and checks reads and pins
 */
`timescale 1ns/1ps

module board_ctrl_tb;
    import board_ctrl_pkg::*;

    localparam int HALF_SCLK      = 8;      // clk125M cycles per sclk half period
    localparam int ABORT_BITS     = 12;
    localparam int SCRATCH_FRAMES = 2 * TEST_ARRAY_COUNT;

    logic                  clk125M = 1'b0;
    logic                  rst_n_i;
    logic                  spi_cs_n_i;
    logic                  spi_sclk_i;
    logic                  spi_mosi_i;
    logic                  spi_miso_o;
    logic [PORT_COUNT-1:0] mac_link_i;
    logic                  channel_up_i;
    logic [PORT_COUNT-1:0] phy_rst_n_o;
    logic                  mdc_o;
    logic                  mdio_o;
    logic                  mdio_oe_o;
    logic                  mdio_i;

    // expected pin state, follows the writes
    logic [PORT_COUNT-1:0] exp_phy = '0;
    logic                  exp_mdc = 1'b0;
    logic                  exp_mdio = 1'b0;
    logic                  exp_oe = 1'b0;

    string                 vec_op[$];
    logic [REG_AW-1:0]     vec_addr[$];
    logic [REG_DW-1:0]     vec_data[$];

    int                    seed = 32'hfcab_e2d7;
    int                    cycle_cnt = 0;
    int                    timeout_cycles = 0;   // set once the vectors are counted

    board_ctrl_top uut (
        .clk125M      (clk125M),
        .rst_n_i      (rst_n_i),
        .spi_cs_n_i   (spi_cs_n_i),
        .spi_sclk_i   (spi_sclk_i),
        .spi_mosi_i   (spi_mosi_i),
        .spi_miso_o   (spi_miso_o),
        .mac_link_i   (mac_link_i),
        .channel_up_i (channel_up_i),
        .phy_rst_n_o  (phy_rst_n_o),
        .mdc_o        (mdc_o),
        .mdio_o       (mdio_o),
        .mdio_oe_o    (mdio_oe_o),
        .mdio_i       (mdio_i)
    );

    always #4 clk125M = ~clk125M;   // 125 MHz

    always @(posedge clk125M) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_cycles != 0 && cycle_cnt >= timeout_cycles) begin
            $display("run hung, no progress after %0d cycles", cycle_cnt);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk125M);
        #1;     // drive point after the edge
    endtask

    task automatic check_value(input string name, input logic [REG_DW-1:0] expected,
                               input logic [REG_DW-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_ports(input string name);
        check_value({name, " phy_rst_n_o"}, REG_DW'(exp_phy), REG_DW'(phy_rst_n_o));
        check_value({name, " mdc_o"}, REG_DW'(exp_mdc), REG_DW'(mdc_o));
        check_value({name, " mdio_o"}, REG_DW'(exp_mdio), REG_DW'(mdio_o));
        check_value({name, " mdio_oe_o"}, REG_DW'(exp_oe), REG_DW'(mdio_oe_o));
        check_value({name, " spi_miso_o idle"}, REG_DW'(1'b1), REG_DW'(spi_miso_o));
    endtask

    // mode 0, msb first; miso taken at each rising sclk edge
    task automatic spi_frame(input spi_op_e op, input logic [REG_AW-1:0] addr,
                             input logic [REG_DW-1:0] data, input int nbits,
                             output logic [REG_DW-1:0] rdata);
        logic [FRAME_BITS-1:0] frame;
        frame = {op, addr, data};
        rdata = '0;
        spi_cs_n_i = 1'b0;
        for (int i = 0; i < nbits; i++) begin
            spi_mosi_i = frame[FRAME_BITS-1-i];
            wait_cycles(HALF_SCLK);
            spi_sclk_i = 1'b1;
            if (i >= CMD_W)
                rdata = {rdata[REG_DW-2:0], spi_miso_o};
            wait_cycles(HALF_SCLK);
            spi_sclk_i = 1'b0;
        end
        wait_cycles(HALF_SCLK);
        spi_cs_n_i = 1'b1;
        spi_mosi_i = 1'b0;
        wait_cycles(HALF_SCLK);     // write has landed by now
    endtask

    task automatic load_vectors();
        int          fd;
        int          rc;
        int          c;
        string       op;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("dv/board_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/board_ctrl_vectors.txt");
            $display("Test failed");
            $fatal(1, "no vector file");
        end
        while (!$feof(fd)) begin
            rc = $fscanf(fd, "%s", op);
            if (rc != 1)
                break;
            if (op.getc(0) == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1)  // skip to end of line
                    c = $fgetc(fd);
            end else begin
                rc = $fscanf(fd, "%h %h", a, d);
                if (rc != 2) begin
                    $display("vector file line after op %s is malformed", op);
                    $display("Test failed");
                    $fatal(1, "bad vector");
                end
                vec_op.push_back(op);
                vec_addr.push_back(a[REG_AW-1:0]);
                vec_data.push_back(d[REG_DW-1:0]);
            end
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // test sections
    // --------------------------------------------------
    task automatic scratch_test();
        logic [REG_DW-1:0] exp_scratch [TEST_ARRAY_COUNT];
        logic [REG_DW-1:0] rdata;
        logic [REG_AW-1:0] addr;
        int                rnd;
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            rnd = $random(seed);
            exp_scratch[i] = rnd[REG_DW-1:0];
            addr = REG_TEST_ARRAY + REG_AW'(i);
            spi_frame(OP_WRITE, addr, exp_scratch[i], FRAME_BITS, rdata);
        end
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            addr = REG_TEST_ARRAY + REG_AW'(i);
            spi_frame(OP_READ, addr, '0, FRAME_BITS, rdata);
            check_value($sformatf("scratch readback 0x%02h", addr), exp_scratch[i], rdata);
        end
        check_ports("scratch");
    endtask

    task automatic run_vectors();
        logic [REG_DW-1:0] rdata;
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] data;
        string             name;
        for (int idx = 0; idx < vec_op.size(); idx++) begin
            addr = vec_addr[idx];
            data = vec_data[idx];
            name = $sformatf("vector %0d %s 0x%02h", idx, vec_op[idx], addr);
            if (vec_op[idx] == "W") begin
                spi_frame(OP_WRITE, addr, data, FRAME_BITS, rdata);
                if (addr == REG_PHY_RST)
                    exp_phy = data[PORT_COUNT-1:0];
                else if (addr == REG_MDC)
                    exp_mdc = data[0];
                else if (addr == REG_MDIO_OUT)
                    exp_mdio = data[0];
                else if (addr == REG_MDIO_DIR)
                    exp_oe = data[0];
                check_ports(name);
            end else if (vec_op[idx] == "R") begin
                spi_frame(OP_READ, addr, '0, FRAME_BITS, rdata);
                check_value(name, data, rdata);
                check_ports(name);
            end else if (vec_op[idx] == "A") begin
                spi_frame(OP_WRITE, addr, data, ABORT_BITS, rdata);
                check_ports(name);     // nothing may change
            end else if (vec_op[idx] == "S") begin
                if (addr == RREG_MAC_LINK)
                    mac_link_i = data[PORT_COUNT-1:0];
                else if (addr == RREG_CHANNEL_UP)
                    channel_up_i = data[0];
                else if (addr == RREG_MDIO_IN)
                    mdio_i = data[0];
                else begin
                    $display("%s names no status input", name);
                    $display("Test failed");
                    $fatal(1, "bad status vector");
                end
                wait_cycles(2);
            end else begin
                $display("%s has an unknown operation", name);
                $display("Test failed");
                $fatal(1, "bad vector op");
            end
        end
    endtask

    initial begin
        rst_n_i      = 1'b0;
        spi_cs_n_i   = 1'b1;
        spi_sclk_i   = 1'b0;
        spi_mosi_i   = 1'b0;
        mac_link_i   = '0;
        channel_up_i = 1'b0;
        mdio_i       = 1'b0;

        load_vectors();
        timeout_cycles = (vec_op.size() + SCRATCH_FRAMES + 1) * FRAME_BITS
                         * 2 * HALF_SCLK * 2;

        wait_cycles(10);
        rst_n_i = 1'b1;
        wait_cycles(4);
        check_ports("after reset");

        scratch_test();
        run_vectors();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: source/board_ctrl_top.sv
/*
 * board control top
 * spi slave in front of the board register bank
 */
`timescale 1ns/1ps

module board_ctrl_top
    import board_ctrl_pkg::*;
(
    input  logic                  clk125M,
    input  logic                  rst_n_i,

    // host spi
    input  logic                  spi_cs_n_i,
    input  logic                  spi_sclk_i,
    input  logic                  spi_mosi_i,
    output logic                  spi_miso_o,

    // status
    input  logic [PORT_COUNT-1:0] mac_link_i,
    input  logic                  channel_up_i,

    // phy management
    output logic [PORT_COUNT-1:0] phy_rst_n_o,
    output logic                  mdc_o,
    output logic                  mdio_o,
    output logic                  mdio_oe_o,
    input  logic                  mdio_i
);

    // sampler -> deframer
    logic              sclk_rise;
    logic              sclk_fall;
    logic              mosi_bit;
    logic              cs_active;

    // deframer <-> register bank
    logic              rd_stb;
    logic              wr_stb;
    logic [REG_AW-1:0] rd_addr;
    logic [REG_AW-1:0] wr_addr;
    logic [REG_DW-1:0] wr_data;
    logic [REG_DW-1:0] rd_data;

    spi_sampler u_sampler (
        .clk125M     (clk125M),
        .rst_n_i     (rst_n_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_sclk_i  (spi_sclk_i),
        .spi_mosi_i  (spi_mosi_i),
        .sclk_rise_o (sclk_rise),
        .sclk_fall_o (sclk_fall),
        .mosi_bit_o  (mosi_bit),
        .cs_active_o (cs_active)
    );

    spi_deframer u_deframer (
        .clk125M     (clk125M),
        .rst_n_i     (rst_n_i),
        .sclk_rise_i (sclk_rise),
        .sclk_fall_i (sclk_fall),
        .mosi_bit_i  (mosi_bit),
        .cs_active_i (cs_active),
        .rd_data_i   (rd_data),
        .rd_stb_o    (rd_stb),
        .wr_stb_o    (wr_stb),
        .rd_addr_o   (rd_addr),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data),
        .spi_miso_o  (spi_miso_o)
    );

    reg_bank u_reg_bank (
        .clk125M      (clk125M),
        .rst_n_i      (rst_n_i),
        .rd_stb_i     (rd_stb),
        .wr_stb_i     (wr_stb),
        .rd_addr_i    (rd_addr),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .mac_link_i   (mac_link_i),
        .channel_up_i (channel_up_i),
        .mdio_i       (mdio_i),
        .rd_data_o    (rd_data),
        .phy_rst_n_o  (phy_rst_n_o),
        .mdc_o        (mdc_o),
        .mdio_o       (mdio_o),
        .mdio_oe_o    (mdio_oe_o)
    );

endmodule

// File: source/reg_bank.sv
/*
 * board control register bank
 * scratch array, phy reset and mdio bit-bang registers, read mux
 */
`timescale 1ns/1ps

module reg_bank
    import board_ctrl_pkg::*;
(
    input  logic                  clk125M,
    input  logic                  rst_n_i,
    input  logic                  rd_stb_i,
    input  logic                  wr_stb_i,
    input  logic [REG_AW-1:0]     rd_addr_i,
    input  logic [REG_AW-1:0]     wr_addr_i,
    input  logic [REG_DW-1:0]     wr_data_i,
    input  logic [PORT_COUNT-1:0] mac_link_i,
    input  logic                  channel_up_i,
    input  logic                  mdio_i,
    output logic [REG_DW-1:0]     rd_data_o,
    output logic [PORT_COUNT-1:0] phy_rst_n_o,
    output logic                  mdc_o,
    output logic                  mdio_o,
    output logic                  mdio_oe_o
);

    logic [TEST_ARRAY_COUNT-1:0][REG_DW-1:0] test_array;
    logic [REG_DW-1:0]                       rd_mux;
    logic                                    ro_wr;

    // --------------------------------------------------
    // write side
    // --------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            test_array  <= '0;
            phy_rst_n_o <= '0;  // phys held in reset
            mdc_o       <= 1'b0;
            mdio_o      <= 1'b0;
            mdio_oe_o   <= 1'b0;
        end else if (wr_stb_i) begin
            case (wr_addr_i)
                REG_PHY_RST:  phy_rst_n_o <= wr_data_i[PORT_COUNT-1:0];
                REG_MDC:      mdc_o       <= wr_data_i[0];
                REG_MDIO_OUT: mdio_o      <= wr_data_i[0];
                REG_MDIO_DIR: mdio_oe_o   <= wr_data_i[0];
                default: ;  // read-only or unmapped
            endcase
            for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
                if (wr_addr_i == REG_TEST_ARRAY + REG_AW'(i))
                    test_array[i] <= wr_data_i;
            end
        end
    end

    // --------------------------------------------------
    // read side
    // --------------------------------------------------
    always_comb begin
        rd_mux = '0;    // unmapped reads as zero
        case (rd_addr_i)
            RREG_FW_DATE_HI: rd_mux = FW_DATE[31:16];
            RREG_FW_DATE_LO: rd_mux = FW_DATE[15:0];
            RREG_FW_TIME_HI: rd_mux = FW_TIME[31:16];
            RREG_FW_TIME_LO: rd_mux = FW_TIME[15:0];
            RREG_MAC_LINK:   rd_mux = REG_DW'(mac_link_i);
            RREG_CHANNEL_UP: rd_mux = REG_DW'(channel_up_i);
            RREG_MDIO_IN:    rd_mux = REG_DW'(mdio_i);
            REG_PHY_RST:     rd_mux = REG_DW'(phy_rst_n_o);
            REG_MDC:         rd_mux = REG_DW'(mdc_o);
            REG_MDIO_OUT:    rd_mux = REG_DW'(mdio_o);
            REG_MDIO_DIR:    rd_mux = REG_DW'(mdio_oe_o);
            default: ;
        endcase
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            if (rd_addr_i == REG_TEST_ARRAY + REG_AW'(i))
                rd_mux = test_array[i];
        end
    end

    always_ff @(posedge clk125M) begin
        if (!rst_n_i)
            rd_data_o <= '0;
        else if (rd_stb_i)
            rd_data_o <= rd_mux;    // valid one cycle after the strobe
    end

    assign ro_wr = wr_stb_i && (wr_addr_i inside {RREG_FW_DATE_HI, RREG_FW_DATE_LO,
                                                  RREG_FW_TIME_HI, RREG_FW_TIME_LO,
                                                  RREG_MAC_LINK, RREG_CHANNEL_UP,
                                                  RREG_MDIO_IN});

    // writes to read-only addresses must not land in any writable register
    a_ro_write_ignored : assert property (@(posedge clk125M) disable iff (!rst_n_i)
        ro_wr |=> $stable({test_array, phy_rst_n_o, mdc_o, mdio_o, mdio_oe_o}));

endmodule

// File: spi/spi_deframer.sv
/*
 * spi deframer
 * turns 24-bit mode 0 frames into register strobes, shifts read data out
 */
`timescale 1ns/1ps

module spi_deframer
    import board_ctrl_pkg::*;
(
    input  logic              clk125M,
    input  logic              rst_n_i,
    input  logic              sclk_rise_i,
    input  logic              sclk_fall_i,
    input  logic              mosi_bit_i,
    input  logic              cs_active_i,
    input  logic [REG_DW-1:0] rd_data_i,
    output logic              rd_stb_o,
    output logic              wr_stb_o,
    output logic [REG_AW-1:0] rd_addr_o,
    output logic [REG_AW-1:0] wr_addr_o,
    output logic [REG_DW-1:0] wr_data_o,
    output logic              spi_miso_o
);

    frame_state_e         state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 load_pend;    // rd_data is valid this cycle

    logic [CMD_W-2:0]     cmd_sr;
    logic [CMD_W-1:0]     cmd_next;
    logic [REG_DW-1:0]    data_sr;
    logic [REG_DW-1:0]    tx_sr;        // read data on its way to miso
    logic [REG_AW-1:0]    addr_q;
    spi_op_e              op_q;
    spi_op_e              op_next;

    assign cmd_next = {cmd_sr, mosi_bit_i};
    assign op_next  = spi_op_e'(cmd_next[CMD_W-1]);

    assign rd_addr_o = addr_q;
    assign wr_addr_o = addr_q;
    assign wr_data_o = data_sr;

    // --------------------------------------------------
    // frame FSM
    // --------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            state      <= ST_IDLE;
            bit_cnt    <= '0;
            rd_stb_o   <= 1'b0;
            wr_stb_o   <= 1'b0;
            load_pend  <= 1'b0;
            spi_miso_o <= 1'b1;
        end else begin
            rd_stb_o  <= 1'b0;
            wr_stb_o  <= 1'b0;
            load_pend <= rd_stb_o;  // bank answers one cycle after the strobe

            if (!cs_active_i) begin
                // cs high ends or aborts the frame
                state      <= ST_IDLE;
                bit_cnt    <= '0;
                load_pend  <= 1'b0;
                spi_miso_o <= 1'b1;
            end else begin
                case (state)
                    ST_IDLE: begin
                        state   <= ST_CMD;
                        bit_cnt <= '0;
                    end
                    ST_CMD: begin
                        if (sclk_rise_i) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_CNT_W'(CMD_W - 1)) begin
                                state <= ST_DATA;
                                if (op_next == OP_READ)
                                    rd_stb_o <= 1'b1;   // fetched early so data leaves from bit 9
                            end
                        end
                    end
                    ST_DATA: begin
                        if (sclk_rise_i) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
                                state <= ST_END;
                                if (op_q == OP_WRITE)
                                    wr_stb_o <= 1'b1;
                            end
                        end
                        if (sclk_fall_i)
                            spi_miso_o <= tx_sr[REG_DW-1];
                    end
                    ST_END: begin
                        // extra clocks are ignored until cs rises
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // shift registers
    // --------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (state == ST_CMD && sclk_rise_i) begin
            cmd_sr <= cmd_next[CMD_W-2:0];
            if (bit_cnt == BIT_CNT_W'(CMD_W - 1)) begin
                op_q   <= op_next;
                addr_q <= cmd_next[REG_AW-1:0];
            end
        end

        if (state == ST_DATA && sclk_rise_i)
            data_sr <= {data_sr[REG_DW-2:0], mosi_bit_i};

        if (!cs_active_i)
            tx_sr <= '1;    // write frames clock out ones
        else if (load_pend)
            tx_sr <= rd_data_i;
        else if (state == ST_DATA && sclk_fall_i)
            tx_sr <= {tx_sr[REG_DW-2:0], 1'b1};
    end

    a_stb_exclusive : assert property (@(posedge clk125M) disable iff (!rst_n_i)
        !(rd_stb_o && wr_stb_o));

    // a write only completes on a full frame
    a_wr_full_frame : assert property (@(posedge clk125M) disable iff (!rst_n_i)
        wr_stb_o |-> bit_cnt == BIT_CNT_W'(FRAME_BITS));

endmodule

// File: spi/spi_sampler.sv
/*
 * spi pin sampler
 * brings cs/sclk/mosi into clk125M and makes sclk edge pulses
 */
`timescale 1ns/1ps

module spi_sampler (
    input  logic clk125M,
    input  logic rst_n_i,
    input  logic spi_cs_n_i,
    input  logic spi_sclk_i,
    input  logic spi_mosi_i,
    output logic sclk_rise_o,
    output logic sclk_fall_o,
    output logic mosi_bit_o,
    output logic cs_active_o
);

    logic [1:0] cs_n_sync;
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic       sclk_prev;  // last synced sclk level

    // two-flop synchronizers
    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            cs_n_sync <= 2'b11;
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            sclk_prev <= 1'b0;
        end else begin
            cs_n_sync <= {cs_n_sync[0], spi_cs_n_i};
            sclk_sync <= {sclk_sync[0], spi_sclk_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            sclk_prev <= sclk_sync[1];
        end
    end

    // edge pulses, registered so pin to pulse is 3 cycles
    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            sclk_rise_o <= 1'b0;
            sclk_fall_o <= 1'b0;
            mosi_bit_o  <= 1'b0;
            cs_active_o <= 1'b0;
        end else begin
            sclk_rise_o <= sclk_sync[1] & ~sclk_prev & ~cs_n_sync[1];
            sclk_fall_o <= ~sclk_sync[1] & sclk_prev & ~cs_n_sync[1];
            mosi_bit_o  <= mosi_sync[1];    // aligned with the rise pulse
            cs_active_o <= ~cs_n_sync[1];
        end
    end

    a_edges_exclusive : assert property (@(posedge clk125M) disable iff (!rst_n_i)
        !(sclk_rise_o && sclk_fall_o));

endmodule

// File: common/board_ctrl_pkg.sv
/*
 * board control package
 * widths, register map, firmware stamp and shared enums
 */

package board_ctrl_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int REG_DW           = 16;   // register data width
    localparam int REG_AW           = 7;    // register address width
    localparam int CMD_W            = 8;    // opcode bit + address
    localparam int FRAME_BITS       = CMD_W + REG_DW;
    localparam int BIT_CNT_W        = $clog2(FRAME_BITS + 1);

    localparam int PORT_COUNT       = 4;    // ethernet ports
    localparam int TEST_ARRAY_COUNT = 4;    // scratch registers

    // --------------------------------------------------
    // read-only addresses
    // --------------------------------------------------
    localparam logic [REG_AW-1:0] RREG_FW_DATE_HI = 7'h00;
    localparam logic [REG_AW-1:0] RREG_FW_DATE_LO = 7'h01;
    localparam logic [REG_AW-1:0] RREG_FW_TIME_HI = 7'h02;
    localparam logic [REG_AW-1:0] RREG_FW_TIME_LO = 7'h03;
    localparam logic [REG_AW-1:0] RREG_MAC_LINK   = 7'h04;  // link bits in low bits
    localparam logic [REG_AW-1:0] RREG_CHANNEL_UP = 7'h05;  // bit 0
    localparam logic [REG_AW-1:0] RREG_MDIO_IN    = 7'h24;  // mdio pin, bit 0

    // --------------------------------------------------
    // read/write addresses
    // --------------------------------------------------
    localparam logic [REG_AW-1:0] REG_TEST_ARRAY  = 7'h10;  // 0x10..0x13
    localparam logic [REG_AW-1:0] REG_PHY_RST     = 7'h20;  // one bit per port, low = reset
    localparam logic [REG_AW-1:0] REG_MDC         = 7'h21;
    localparam logic [REG_AW-1:0] REG_MDIO_OUT    = 7'h22;
    localparam logic [REG_AW-1:0] REG_MDIO_DIR    = 7'h23;  // 1 = fpga drives mdio

    // build stamp, read back as hi/lo words
    localparam logic [31:0] FW_DATE = 32'h2024_0517;
    localparam logic [31:0] FW_TIME = 32'h0013_4500;

    // first bit of every spi frame
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } spi_op_e;

    // deframer state
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_DATA,
        ST_END
    } frame_state_e;

endpackage
